// File: files.f
+incdir+include
source/la_pkg.sv
source/la_reg_decode.sv
source/la_trigger.sv
source/la_capture_ctrl.sv
source/la_sample_pack.sv
source/la_top.sv
verif/la_chk.sv
verif/la_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the logic analyzer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module la_tb -f files.f

# The run may stop on $fatal; the log decides the result
./obj_dir/Vla_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

// File: source/la_capture_ctrl.sv
`timescale 1ns/1ps

module la_capture_ctrl (
   input  logic              observer_clk,
   input  logic              reset,
   input  logic              capture_go,
   input  la_pkg::la_count_t capture_depth,
   input  la_pkg::la_count_t downsample,
   output logic              capturing,
   output logic              sample_en,
   output logic              fifo_wr
);

   la_pkg::la_count_t ds_count;      // Downsample divider
   logic              ds_tick;
   la_pkg::la_count_t sample_count;  // Samples taken so far
   logic              pair;          // High once the first of a pair is in

   // Divider restarts with every capture so the first sample lands at a fixed offset
   always_ff @(posedge observer_clk) begin
      if (reset || capture_go) begin
         ds_count <= '0;
         ds_tick  <= 1'b0;
      end else if (ds_count == downsample) begin
         ds_count <= '0;
         ds_tick  <= 1'b1;
      end else begin
         ds_count <= ds_count + 1'b1;
         ds_tick  <= 1'b0;
      end
   end

   assign sample_en = capturing & ds_tick;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing    <= 1'b0;
         sample_count <= '0;
         pair         <= 1'b0;
         fifo_wr      <= 1'b0;
      end else if (capture_go) begin
         capturing    <= 1'b1;
         sample_count <= '0;
         pair         <= 1'b0;
         fifo_wr      <= 1'b0;
      end else if (sample_en) begin
         pair         <= ~pair;
         fifo_wr      <= pair;  // Word is complete after the second sample
         sample_count <= sample_count + 1'b1;
         if (sample_count == capture_depth - 16'd1)
            capturing <= 1'b0;  // Last sample
      end else begin
         fifo_wr <= 1'b0;
      end
   end

endmodule

// File: source/la_pkg.sv
package la_pkg;

   // Field widths
   localparam int la_addr_width  = 8;
   localparam int la_data_width  = 8;
   localparam int la_count_width = 16;
   localparam int la_group_width = 3;
   localparam int la_trig_width  = 5;
   localparam int la_chan_count  = 9;
   localparam int la_word_width  = 2 * la_chan_count;  // Two samples per channel

   typedef logic [la_addr_width-1:0]  la_addr_t;
   typedef logic [la_data_width-1:0]  la_data_t;
   typedef logic [la_count_width-1:0] la_count_t;
   typedef logic [la_group_width-1:0] la_group_t;
   typedef logic [la_trig_width-1:0]  la_trig_sel_t;
   typedef logic [la_chan_count-1:0]  la_chan_t;
   typedef logic [la_word_width-1:0]  la_fifo_word_t;

   // Register map
   localparam la_addr_t la_addr_group      = 8'd0;
   localparam la_addr_t la_addr_status     = 8'd1;
   localparam la_addr_t la_addr_trig_src   = 8'd2;
   localparam la_addr_t la_addr_depth      = 8'd3;  // 16 bits, byte lanes
   localparam la_addr_t la_addr_downsample = 8'd4;  // 16 bits, byte lanes
   localparam la_addr_t la_addr_arm        = 8'd5;
   localparam la_addr_t la_addr_manual     = 8'd6;

   // Capture groups
   localparam la_group_t la_grp_pins   = 3'd0;
   localparam la_group_t la_grp_userio = 3'd1;
   localparam la_group_t la_grp_debug  = 3'd2;

   // Trigger sources
   localparam la_trig_sel_t la_trig_ext         = 5'd0;
   localparam la_trig_sel_t la_trig_dbg0        = 5'd1;
   localparam la_trig_sel_t la_trig_dbg1        = 5'd2;
   localparam la_trig_sel_t la_trig_userio_base = 5'd8;  // 8..15 pick userio[0..7]
   localparam int           la_trig_invert_bit  = 4;

   // Reset values of the configuration registers
   localparam la_group_t    la_group_default = la_grp_pins;
   localparam la_trig_sel_t la_trig_default  = la_trig_ext;
   localparam la_count_t    la_count_default = '0;

   // Shown on every unused group code
   localparam la_chan_t la_test_pattern = 9'b1_0101_0101;

endpackage

// File: source/la_reg_decode.sv
`timescale 1ns/1ps

module la_reg_decode #(
   parameter int bytecnt_width = 7
) (
   input  logic                     observer_clk,
   input  logic                     reset,
   input  la_pkg::la_addr_t         reg_address,
   input  logic [bytecnt_width-1:0] reg_bytecnt,
   input  la_pkg::la_data_t         reg_datai,
   output la_pkg::la_data_t         reg_datao,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  logic                     capturing,
   input  logic                     armed,
   input  logic                     capture_go,
   input  logic                     fifo_empty,
   output la_pkg::la_group_t        group_sel,
   output la_pkg::la_trig_sel_t     trig_sel,
   output la_pkg::la_count_t        capture_depth,
   output la_pkg::la_count_t        downsample,
   output logic                     manual_capture,
   output logic                     arm,
   output logic                     fifo_flush
);

   localparam int lane_count = 2;  // Byte lanes in a 16-bit register
   localparam int group_pad  = la_pkg::la_data_width - la_pkg::la_group_width;
   localparam int trig_pad   = la_pkg::la_data_width - la_pkg::la_trig_width;

   logic lane;
   logic lane_valid;

   assign lane       = reg_bytecnt[0];
   assign lane_valid = int'(reg_bytecnt) < lane_count;  // Higher byte counts are ignored

   // Configuration registers
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         group_sel      <= la_pkg::la_group_default;
         trig_sel       <= la_pkg::la_trig_default;
         capture_depth  <= la_pkg::la_count_default;
         downsample     <= la_pkg::la_count_default;
         manual_capture <= 1'b0;
      end else if (reg_write) begin
         case (reg_address)
            la_pkg::la_addr_group:
               group_sel <= reg_datai[la_pkg::la_group_width-1:0];
            la_pkg::la_addr_trig_src:
               trig_sel <= reg_datai[la_pkg::la_trig_width-1:0];
            la_pkg::la_addr_depth: begin
               if (lane_valid)
                  capture_depth[8*lane +: 8] <= reg_datai;
            end
            la_pkg::la_addr_downsample: begin
               if (lane_valid)
                  downsample[8*lane +: 8] <= reg_datai;
            end
            la_pkg::la_addr_manual:
               manual_capture <= reg_datai[0];
            default: ;
         endcase
      end
   end

   // Arm stays set until the trigger fires
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm <= 1'b0;
      end else if (reg_write && (reg_address == la_pkg::la_addr_arm)) begin
         arm <= reg_datai[0];
      end else if (capture_go) begin
         arm <= 1'b0;
      end
   end

   // Flush request raised by arming, dropped once the FIFO reports empty
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         fifo_flush <= 1'b0;
      end else if (fifo_empty) begin
         fifo_flush <= 1'b0;
      end else if (arm && !fifo_flush) begin
         fifo_flush <= 1'b1;
      end
   end

   // Readback
   always_comb begin
      reg_datao = '0;
      if (reg_read) begin
         case (reg_address)
            la_pkg::la_addr_group:
               reg_datao = {{group_pad{1'b0}}, group_sel};
            la_pkg::la_addr_status:
               reg_datao = {6'b0, armed, capturing};
            la_pkg::la_addr_trig_src:
               reg_datao = {{trig_pad{1'b0}}, trig_sel};
            la_pkg::la_addr_depth:
               reg_datao = lane_valid ? capture_depth[8*lane +: 8] : 8'h00;
            la_pkg::la_addr_downsample:
               reg_datao = lane_valid ? downsample[8*lane +: 8] : 8'h00;
            la_pkg::la_addr_arm:
               reg_datao = {7'b0, arm};
            la_pkg::la_addr_manual:
               reg_datao = {7'b0, manual_capture};
            default:
               reg_datao = '0;  // Unmapped
         endcase
      end
   end

endmodule

// File: source/la_sample_pack.sv
`timescale 1ns/1ps

module la_sample_pack (
   input  logic                  observer_clk,
   input  logic                  reset,
   input  la_pkg::la_group_t     group_sel,
   input  logic                  sample_en,
   input  la_pkg::la_chan_t      pins,
   input  logic [7:0]            userio,
   input  logic                  userio_clk,
   input  la_pkg::la_chan_t      debug_bus,
   output la_pkg::la_fifo_word_t fifo_wr_data
);

   la_pkg::la_chan_t src_q;   // Selected group, registered
   la_pkg::la_chan_t newer;
   la_pkg::la_chan_t older;

   always_ff @(posedge observer_clk) begin
      case (group_sel)
         la_pkg::la_grp_pins:   src_q <= pins;
         la_pkg::la_grp_userio: src_q <= {userio_clk, userio};  // Clock on channel 8
         la_pkg::la_grp_debug:  src_q <= debug_bus;
         default:               src_q <= la_pkg::la_test_pattern;
      endcase
   end

   // Two-deep history per channel
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         newer <= '0;
         older <= '0;
      end else if (sample_en) begin
         older <= newer;
         newer <= src_q;
      end
   end

   // Interleave so each channel owns two adjacent bits
   always_comb begin
      for (int n = 0; n < la_pkg::la_chan_count; n++) begin
         fifo_wr_data[2*n+1] = older[n];
         fifo_wr_data[2*n]   = newer[n];
      end
   end

endmodule

// File: source/la_top.sv
`timescale 1ns/1ps

module la_top #(
   parameter int bytecnt_width = 7
) (
   input  logic                     observer_clk,
   input  logic                     reset,
   input  la_pkg::la_addr_t         reg_address,
   input  logic [bytecnt_width-1:0] reg_bytecnt,
   input  la_pkg::la_data_t         reg_datai,
   output la_pkg::la_data_t         reg_datao,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  la_pkg::la_chan_t         pins,
   input  logic [7:0]               userio,
   input  logic                     userio_clk,
   input  la_pkg::la_chan_t         debug_bus,
   input  logic                     ext_trigger,
   output logic                     fifo_wr,
   output la_pkg::la_fifo_word_t    fifo_wr_data,
   output logic                     fifo_flush,
   input  logic                     fifo_empty
);

   la_pkg::la_group_t    group_sel;
   la_pkg::la_trig_sel_t trig_sel;
   la_pkg::la_count_t    capture_depth;
   la_pkg::la_count_t    downsample;
   logic                 manual_capture;
   logic                 arm;
   logic                 armed;
   logic                 capture_go;
   logic                 capturing;
   logic                 sample_en;

   la_reg_decode #(
      .bytecnt_width (bytecnt_width)
   ) decode_i (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datai      (reg_datai),
      .reg_datao      (reg_datao),
      .reg_read       (reg_read),
      .reg_write      (reg_write),
      .capturing      (capturing),
      .armed          (armed),
      .capture_go     (capture_go),
      .fifo_empty     (fifo_empty),
      .group_sel      (group_sel),
      .trig_sel       (trig_sel),
      .capture_depth  (capture_depth),
      .downsample     (downsample),
      .manual_capture (manual_capture),
      .arm            (arm),
      .fifo_flush     (fifo_flush)
   );

   la_trigger trigger_i (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .trig_sel       (trig_sel),
      .manual_capture (manual_capture),
      .arm            (arm),
      .capturing      (capturing),
      .ext_trigger    (ext_trigger),
      .debug_bus      (debug_bus),
      .userio         (userio),
      .capture_go     (capture_go),
      .armed          (armed)
   );

   la_capture_ctrl execute_i (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .capture_go    (capture_go),
      .capture_depth (capture_depth),
      .downsample    (downsample),
      .capturing     (capturing),
      .sample_en     (sample_en),
      .fifo_wr       (fifo_wr)
   );

   la_sample_pack result_i (
      .observer_clk (observer_clk),
      .reset        (reset),
      .group_sel    (group_sel),
      .sample_en    (sample_en),
      .pins         (pins),
      .userio       (userio),
      .userio_clk   (userio_clk),
      .debug_bus    (debug_bus),
      .fifo_wr_data (fifo_wr_data)
   );

endmodule

// File: source/la_trigger.sv
`timescale 1ns/1ps

module la_trigger (
   input  logic                 observer_clk,
   input  logic                 reset,
   input  la_pkg::la_trig_sel_t trig_sel,
   input  logic                 manual_capture,
   input  logic                 arm,
   input  logic                 capturing,
   input  logic                 ext_trigger,
   input  la_pkg::la_chan_t     debug_bus,
   input  logic [7:0]           userio,
   output logic                 capture_go,
   output logic                 armed
);

   logic       trig_src;
   logic       trig_async;
   logic [1:0] trig_sync;  // Pins may be asynchronous to observer_clk
   logic       trig_d;
   logic       arm_d;

   // Source select
   always_comb begin
      trig_src = 1'b0;
      if (trig_sel[3:0] >= la_pkg::la_trig_userio_base[3:0]) begin
         // Bit 4 flips polarity so a falling userio edge can trigger
         trig_src = userio[trig_sel[2:0]] ^ trig_sel[la_pkg::la_trig_invert_bit];
      end else begin
         case (trig_sel)
            la_pkg::la_trig_ext:  trig_src = ext_trigger;
            la_pkg::la_trig_dbg0: trig_src = debug_bus[0];
            la_pkg::la_trig_dbg1: trig_src = debug_bus[1];
            default:              trig_src = 1'b0;
         endcase
      end
   end

   assign trig_async = trig_src | manual_capture;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_sync  <= 2'b00;
         trig_d     <= 1'b0;
         capture_go <= 1'b0;
      end else begin
         trig_sync <= {trig_sync[0], trig_async};
         trig_d    <= trig_sync[1];
         // Rising edge only, and never on top of a running capture
         capture_go <= trig_sync[1] & ~trig_d & armed & ~capturing;
      end
   end

   // Armed flag follows the arm register's rising edge
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm_d <= 1'b0;
         armed <= 1'b0;
      end else begin
         arm_d <= arm;
         if (capturing)
            armed <= 1'b0;
         else if (arm && !arm_d)
            armed <= 1'b1;
      end
   end

endmodule

// File: verif/la_chk.sv
`timescale 1ns/1ps

module la_chk (
   input logic observer_clk,
   input logic reset,
   input logic fifo_wr,
   input logic fifo_flush,
   input logic capturing
);

   // One word per pair of samples, never back to back
   wr_single: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr |=> !fifo_wr)
      else $error("fifo_wr high on two consecutive cycles");

   // Last word may land just after capturing drops
   wr_in_capture: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr |-> (capturing || $past(capturing)))
      else $error("fifo_wr outside a capture");

   reset_quiet: assert property (@(posedge observer_clk)
      reset |=> (!fifo_flush && !capturing))
      else $error("fifo_flush or capturing high after reset");

endmodule

bind la_top la_chk chk_i (
   .observer_clk (observer_clk),
   .reset        (reset),
   .fifo_wr      (fifo_wr),
   .fifo_flush   (fifo_flush),
   .capturing    (capturing)
);

// File: include/la_tb_table.svh
`ifndef LA_TB_TABLE_SVH
`define LA_TB_TABLE_SVH

// Each row holds group, trigger select, depth, downsample, arm, fire mode,
// expected word count, fixed word flag and fixed expected word
typedef struct packed {
   la_pkg::la_group_t     group;
   la_pkg::la_trig_sel_t  trig;
   la_pkg::la_count_t     depth;
   la_pkg::la_count_t     ds;
   logic                  do_arm;
   logic [1:0]            fire;
   la_pkg::la_count_t     exp_count;
   logic                  fixed;
   la_pkg::la_fifo_word_t exp_word;
} table_row_t;

localparam logic [1:0] fire_manual = 2'd0;
localparam logic [1:0] fire_ext    = 2'd1;
localparam logic [1:0] fire_userio = 2'd2;  // Falling edge of userio[3] through bit 4
localparam int row_count = 9;

table_row_t rows [row_count];

task automatic load_table();
   rows[0] = '{3'd7, 5'd0, 16'd8, 16'd0, 1'b1, fire_manual, 16'd4, 1'b1, 18'h33333};
   rows[1] = '{3'd0, 5'd0, 16'd6, 16'd0, 1'b1, fire_ext,    16'd3, 1'b0, 18'h0};
   rows[2] = '{3'd0, 5'd0, 16'd6, 16'd3, 1'b1, fire_manual, 16'd3, 1'b0, 18'h0};
   rows[3] = '{3'd1, 5'd0, 16'd6, 16'd0, 1'b1, fire_ext,    16'd3, 1'b0, 18'h0};
   rows[4] = '{3'd1, 5'd0, 16'd4, 16'd3, 1'b1, fire_manual, 16'd2, 1'b0, 18'h0};
   rows[5] = '{3'd2, 5'd0, 16'd6, 16'd0, 1'b1, fire_manual, 16'd3, 1'b0, 18'h0};
   rows[6] = '{3'd2, 5'd0, 16'd5, 16'd3, 1'b1, fire_ext,    16'd2, 1'b0, 18'h0};
   rows[7] = '{3'd0, 5'd27, 16'd4, 16'd0, 1'b1, fire_userio, 16'd2, 1'b0, 18'h0};
   rows[8] = '{3'd0, 5'd0, 16'd4, 16'd0, 1'b0, fire_ext,    16'd0, 1'b0, 18'h0};  // Not armed
endtask

`endif

// File: verif/la_tb.sv
`timescale 1ns/1ps

module la_tb;

   logic                  observer_clk;
   logic                  reset;
   la_pkg::la_addr_t      reg_address;
   logic [6:0]            reg_bytecnt;
   la_pkg::la_data_t      reg_datai;
   la_pkg::la_data_t      reg_datao;
   logic                  reg_read;
   logic                  reg_write;
   la_pkg::la_chan_t      pins;
   logic [7:0]            userio;
   logic                  userio_clk;
   la_pkg::la_chan_t      debug_bus;
   logic                  ext_trigger;
   logic                  fifo_wr;
   la_pkg::la_fifo_word_t fifo_wr_data;
   logic                  fifo_flush;
   logic                  fifo_empty;

   `include "la_tb_table.svh"

   integer                seed = 68278;
   int                    cycles = 0;
   int                    cycle_limit = 0;
   la_pkg::la_count_t     words;
   la_pkg::la_fifo_word_t exp_word;
   la_pkg::la_data_t      rd;

   la_top la_top_i (.*);

   initial begin
      observer_clk = 1'b0;
      forever #2 observer_clk = ~observer_clk;
   end

   task automatic check_word(la_pkg::la_fifo_word_t got, la_pkg::la_fifo_word_t exp,
                             string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "word check failed");
      end
   endtask

   task automatic check_count(la_pkg::la_count_t got, la_pkg::la_count_t exp, string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "count check failed");
      end
   endtask

   task automatic check_reg(la_pkg::la_data_t got, la_pkg::la_data_t exp, string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "register check failed");
      end
   endtask

   task automatic write_reg(la_pkg::la_addr_t addr, int lane, la_pkg::la_data_t data);
      @(posedge observer_clk);
      #1;
      reg_address = addr;
      reg_bytecnt = 7'(lane);
      reg_datai   = data;
      reg_write   = 1'b1;
      @(posedge observer_clk);
      #1;
      reg_write = 1'b0;
   endtask

   // reg_datao is taken at the falling edge
   task automatic read_reg(la_pkg::la_addr_t addr, int lane, output la_pkg::la_data_t data);
      @(posedge observer_clk);
      #1;
      reg_address = addr;
      reg_bytecnt = 7'(lane);
      reg_read    = 1'b1;
      @(negedge observer_clk);
      data = reg_datao;
      @(posedge observer_clk);
      #1;
      reg_read = 1'b0;
   endtask

   task automatic wait_cycles(int n);
      repeat (n) @(posedge observer_clk);
      #1;
   endtask

   function automatic la_pkg::la_fifo_word_t double_bits(la_pkg::la_chan_t c);
      la_pkg::la_fifo_word_t w;
      for (int n = 0; n < 9; n++)
         w[2*n +: 2] = {c[n], c[n]};
      return w;
   endfunction

   // FIFO monitor
   always @(negedge observer_clk) begin
      if (!reset && fifo_wr) begin
         check_word(fifo_wr_data, exp_word, "fifo word");
         words = words + 16'd1;
      end
   end

   always @(posedge observer_clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $fatal(1, "timeout");
      end
   end

   task automatic run_row(table_row_t r);
      write_reg(la_pkg::la_addr_group, 0, 8'(r.group));
      write_reg(la_pkg::la_addr_trig_src, 0, 8'(r.trig));
      write_reg(la_pkg::la_addr_depth, 0, r.depth[7:0]);
      write_reg(la_pkg::la_addr_depth, 1, r.depth[15:8]);
      write_reg(la_pkg::la_addr_downsample, 0, r.ds[7:0]);
      write_reg(la_pkg::la_addr_downsample, 1, r.ds[15:8]);
      pins       = 9'($random(seed));
      userio     = 8'($random(seed));
      userio_clk = 1'($random(seed));
      debug_bus  = 9'($random(seed));
      if (r.fire == fire_userio)
         userio[3] = 1'b0;
      case (r.group)
         la_pkg::la_grp_pins:   exp_word = double_bits(pins);
         la_pkg::la_grp_userio: exp_word = double_bits({userio_clk, userio});
         la_pkg::la_grp_debug:  exp_word = double_bits(debug_bus);
         default:               exp_word = double_bits(la_pkg::la_test_pattern);
      endcase
      if (r.fixed)
         exp_word = r.exp_word;
      words = '0;
      wait_cycles(5);  // Let the synchronizer settle on the new source
      if (r.do_arm)
         write_reg(la_pkg::la_addr_arm, 0, 8'h01);
      wait_cycles(3);
      read_reg(la_pkg::la_addr_arm, 0, rd);
      check_reg(rd, {7'b0, r.do_arm}, "arm before trigger");
      read_reg(la_pkg::la_addr_status, 0, rd);
      check_reg(rd, {6'b0, r.do_arm, 1'b0}, "status before trigger");
      case (r.fire)
         fire_manual: begin
            write_reg(la_pkg::la_addr_manual, 0, 8'h01);
            write_reg(la_pkg::la_addr_manual, 0, 8'h00);
         end
         fire_ext: begin
            ext_trigger = 1'b1;
            wait_cycles(3);
            ext_trigger = 1'b0;
         end
         default: begin
            userio[3] = 1'b1;  // Rising pin edge must not fire
            wait_cycles(15);
            check_count(words, 16'd0, "words after rising userio edge");
            userio[3] = 1'b0;
         end
      endcase
      if (r.exp_count == 0) begin
         wait_cycles(40);
      end else begin
         rd = 8'h00;
         while (rd[0] !== 1'b1)  // Capturing bit in status
            read_reg(la_pkg::la_addr_status, 0, rd);
         while (words < r.exp_count)
            @(posedge observer_clk);
         rd = 8'h01;
         while (rd != 8'h00)
            read_reg(la_pkg::la_addr_status, 0, rd);
         wait_cycles(4);
      end
      check_count(words, r.exp_count, "word count");
      read_reg(la_pkg::la_addr_arm, 0, rd);
      check_reg(rd, 8'h00, "arm after capture");
      read_reg(la_pkg::la_addr_status, 0, rd);
      check_reg(rd, 8'h00, "status after capture");
   endtask

   initial begin
      reset = 1'b1;
      reg_address = '0;
      reg_bytecnt = '0;
      reg_datai = '0;
      reg_read = 1'b0;
      reg_write = 1'b0;
      pins = '0;
      userio = '0;
      userio_clk = 1'b0;
      debug_bus = '0;
      ext_trigger = 1'b0;
      fifo_empty = 1'b1;
      words = '0;
      exp_word = '0;
      load_table();
      for (int i = 0; i < row_count; i++)
         cycle_limit += int'(rows[i].depth) * (int'(rows[i].ds) + 1) + 100;
      cycle_limit += 200;  // Register and flush checks
      repeat (5) @(posedge observer_clk);
      #1;
      reset = 1'b0;

      for (int a = 0; a <= 6; a++) begin
         read_reg(8'(a), 0, rd);
         check_reg(rd, 8'h00, "default");
      end
      read_reg(la_pkg::la_addr_depth, 1, rd);
      check_reg(rd, 8'h00, "depth high default");
      write_reg(la_pkg::la_addr_depth, 0, 8'h34);
      write_reg(la_pkg::la_addr_depth, 1, 8'h12);
      write_reg(la_pkg::la_addr_downsample, 1, 8'hab);
      write_reg(la_pkg::la_addr_group, 0, 8'h05);
      write_reg(la_pkg::la_addr_trig_src, 0, 8'h1b);
      read_reg(la_pkg::la_addr_depth, 0, rd);
      check_reg(rd, 8'h34, "depth low");
      read_reg(la_pkg::la_addr_depth, 1, rd);
      check_reg(rd, 8'h12, "depth high");
      read_reg(la_pkg::la_addr_downsample, 1, rd);
      check_reg(rd, 8'hab, "downsample high");
      read_reg(la_pkg::la_addr_group, 0, rd);
      check_reg(rd, 8'h05, "group");
      read_reg(la_pkg::la_addr_trig_src, 0, rd);
      check_reg(rd, 8'h1b, "trigger select");
      read_reg(8'h09, 0, rd);
      check_reg(rd, 8'h00, "unmapped");

      for (int i = 0; i < row_count; i++)
         run_row(rows[i]);

      // Flush handshake with the FIFO
      fifo_empty = 1'b0;
      wait_cycles(2);
      check_reg({7'b0, fifo_flush}, 8'h00, "flush before arm");
      write_reg(la_pkg::la_addr_arm, 0, 8'h01);
      wait_cycles(3);
      check_reg({7'b0, fifo_flush}, 8'h01, "flush raised");
      fifo_empty = 1'b1;
      wait_cycles(2);
      check_reg({7'b0, fifo_flush}, 8'h00, "flush dropped");
      write_reg(la_pkg::la_addr_arm, 0, 8'h00);

      $display("** PASS **");
      $finish;
   end

endmodule
